/* compile.f */
+incdir+.
i3c_tgt_pkg.sv
i3c_tgt_xfer_if.sv
i3c_tgt_addr_decode.sv
i3c_tgt_fsm.sv
i3c_tgt_rx_path.sv
i3c_tgt_tx_path.sv
i3c_tgt_top.sv
i3c_tgt_asserts.sv
tb_i3c_tgt_clkgen.sv
tb_i3c_tgt_checker.sv
tb_i3c_tgt.sv

/* Bender.yml */
package:
  name: i3c_tgt

export_include_dirs:
  - .

sources:
  - files:
      - i3c_tgt_pkg.sv
      - i3c_tgt_xfer_if.sv
      - i3c_tgt_addr_decode.sv
      - i3c_tgt_fsm.sv
      - i3c_tgt_rx_path.sv
      - i3c_tgt_tx_path.sv
      - i3c_tgt_top.sv
  - target: test
    files:
      - i3c_tgt_asserts.sv
      - tb_i3c_tgt_clkgen.sv
      - tb_i3c_tgt_checker.sv
      - tb_i3c_tgt.sv

/* tb_i3c_tgt.sv */
// I3C target core testbench
// Bus monitor and FIFO models with random reply latency, the test sequence
// and the cycle limit
`timescale 1ns/10ps
`include "i3c_tgt_macros.svh"

module tb_i3c_tgt;
  import i3c_tgt_pkg::*;

  // Planned bus events over all tests
  localparam int N_EVENTS   = 62;
  localparam int MAX_CYCLES = N_EVENTS * 8 + 200;

  localparam int REQ_RX_BYTE = 0;
  localparam int REQ_RX_BIT  = 1;
  localparam int REQ_TX_BYTE = 2;
  localparam int REQ_TX_BIT  = 3;
  localparam int REQ_CCC     = 4;
  localparam int REQ_NACK    = 5;

  logic  clk, rst_n;
  logic  target_enable_i, bus_start_det_i, bus_stop_det_i, bus_rx_done_i, bus_tx_done_i;
  byte_t bus_rx_data_i, tx_fifo_rdata_i;
  logic  tx_fifo_rvalid_i, tx_last_byte_i, rx_fifo_wready_i, ccc_done_i;
  addr_t sta_addr, dyn_addr;
  logic  sta_valid, dyn_valid;
  logic  bus_rx_req_byte_o, bus_rx_req_bit_o, bus_tx_req_byte_o, bus_tx_req_bit_o;
  byte_t bus_tx_value_o, rx_fifo_wdata_o, ccc_o;
  logic  tx_fifo_rready_o, rx_fifo_wvalid_o, rx_last_byte_o, ccc_valid_o, target_idle_o;
  logic  parity_err_o, rx_overflow_err_o, event_target_nack_o;

  logic [31:0] lfsr_q;
  logic        next_ready;
  byte_t       tx_mem[8];
  int          tx_idx, tx_cnt, cycles;

  tb_i3c_tgt_clkgen i_clkgen (.clk_o(clk), .rst_no(rst_n));

  i3c_tgt_top i_dut (
    .clk_i(clk), .rst_ni(rst_n), .target_enable_i,
    .bus_start_det_i, .bus_stop_det_i, .bus_rx_done_i, .bus_rx_data_i, .bus_tx_done_i,
    .bus_rx_req_byte_o, .bus_rx_req_bit_o, .bus_tx_req_byte_o, .bus_tx_req_bit_o,
    .bus_tx_value_o, .tx_fifo_rvalid_i, .tx_fifo_rdata_i, .tx_last_byte_i, .tx_fifo_rready_o,
    .rx_fifo_wready_i, .rx_fifo_wvalid_o, .rx_fifo_wdata_o, .rx_last_byte_o,
    .target_sta_addr_i(sta_addr), .target_sta_addr_valid_i(sta_valid),
    .target_dyn_addr_i(dyn_addr), .target_dyn_addr_valid_i(dyn_valid),
    .ccc_o, .ccc_valid_o, .ccc_done_i, .target_idle_o,
    .parity_err_o, .rx_overflow_err_o, .event_target_nack_o
  );

  tb_i3c_tgt_checker i_chk (
    .clk_i(clk), .rst_ni(rst_n), .wvalid_i(rx_fifo_wvalid_o), .wdata_i(rx_fifo_wdata_o),
    .rx_req_byte_i(bus_rx_req_byte_o), .rx_req_bit_i(bus_rx_req_bit_o),
    .tx_req_byte_i(bus_tx_req_byte_o), .tx_req_bit_i(bus_tx_req_bit_o),
    .tx_done_i(bus_tx_done_i), .tx_value_i(bus_tx_value_o), .pop_i(tx_fifo_rready_o),
    .idle_i(target_idle_o), .nack_i(event_target_nack_o),
    .perr_i(parity_err_o), .ovf_i(rx_overflow_err_o), .last_i(rx_last_byte_o),
    .ccc_i(ccc_o), .ccc_valid_i(ccc_valid_o)
  );

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic int unsigned rand_bits(input int n);
    int unsigned v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = (v << 1) | lfsr_q[0];
    end
    return v;
  endfunction

  // TX FIFO model, next entry is shown after each pop
  always @(posedge clk) begin
    if (tx_fifo_rready_o) begin
      tx_fifo_rvalid_i <= (tx_idx + 1 < tx_cnt);
      tx_fifo_rdata_i  <= tx_mem[(tx_idx + 1) % 8];
      tx_last_byte_i   <= (tx_idx + 1 == tx_cnt - 1);
      tx_idx           <= tx_idx + 1;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > MAX_CYCLES) begin
      $display("timeout after %0d cycles, a request or done never came", cycles);
      $display("TESTS FAILED");
      $finish;
    end
  end

  task automatic wait_req(input int kind);
    logic hit;
    hit = 1'b0;
    while (!hit) begin
      @(negedge clk);
      case (kind)
        REQ_RX_BYTE: hit = bus_rx_req_byte_o;
        REQ_RX_BIT:  hit = bus_rx_req_bit_o;
        REQ_TX_BYTE: hit = bus_tx_req_byte_o;
        REQ_TX_BIT:  hit = bus_tx_req_bit_o;
        REQ_CCC:     hit = ccc_valid_o;
        default:     hit = event_target_nack_o;
      endcase
    end
  endtask

  // Bus reply latency of 1 to 4 cycles
  task automatic bus_delay();
    repeat (1 + rand_bits(2)) @(posedge clk);
  endtask

  task automatic start_cond();
    @(posedge clk);
    bus_start_det_i <= 1'b1;
    @(posedge clk);
    bus_start_det_i <= 1'b0;
  endtask

  task automatic stop_cond();
    @(posedge clk);
    bus_stop_det_i <= 1'b1;
    @(posedge clk);
    bus_stop_det_i <= 1'b0;
  endtask

  task automatic rx_pulse(input byte_t d, input int kind);
    wait_req(kind);
    bus_delay();
    bus_rx_done_i    <= 1'b1;
    bus_rx_data_i    <= d;
    rx_fifo_wready_i <= next_ready;
    @(posedge clk);
    bus_rx_done_i <= 1'b0;
  endtask

  task automatic tx_pulse(input int kind);
    wait_req(kind);
    bus_delay();
    bus_tx_done_i    <= 1'b1;
    rx_fifo_wready_i <= next_ready;
    @(posedge clk);
    bus_tx_done_i <= 1'b0;
  endtask

  task automatic set_config(input addr_t sa, input logic sv, input addr_t da, input logic dv);
    @(posedge clk);
    sta_addr  <= sa;
    sta_valid <= sv;
    dyn_addr  <= da;
    dyn_valid <= dv;
    @(posedge clk);
  endtask

  // Private write, bad and drop pick one byte index or -1 for none
  task automatic do_write(input addr_t a, input int n, input int bad, input int drop,
                          input logic rep);
    byte_t d;
    logic  tbit;
    start_cond();
    if (rep) begin
      rx_pulse(`I3C_RSVD_BYTE, REQ_RX_BYTE);
      tx_pulse(REQ_TX_BIT);
      wait_req(REQ_RX_BYTE);
      start_cond();
    end
    next_ready = (drop != 0);
    rx_pulse({a, 1'b0}, REQ_RX_BYTE);
    tx_pulse(REQ_TX_BIT);
    for (int k = 0; k < n; k++) begin
      d = byte_t'(rand_bits(8));
      tbit = ~(^d) ^ (k == bad);
      i_chk.note_write(d, tbit, k != drop);
      next_ready = (k + 1 != drop);
      rx_pulse(d, REQ_RX_BYTE);
      rx_pulse({7'b0, tbit}, REQ_RX_BIT);
    end
    stop_cond();
  endtask

  task automatic do_read(input addr_t a, input int n);
    for (int k = 0; k < n; k++) begin
      tx_mem[k] = byte_t'(rand_bits(8));
      i_chk.note_read(tx_mem[k], k == n - 1);
    end
    @(posedge clk);
    tx_idx           <= 0;
    tx_cnt           <= n;
    tx_fifo_rvalid_i <= 1'b1;
    tx_fifo_rdata_i  <= tx_mem[0];
    tx_last_byte_i   <= (n == 1);
    start_cond();
    rx_pulse({a, 1'b1}, REQ_RX_BYTE);
    tx_pulse(REQ_TX_BIT);
    for (int k = 0; k < n; k++) begin
      tx_pulse(REQ_TX_BYTE);
      tx_pulse(REQ_TX_BIT);
    end
    stop_cond();
  endtask

  task automatic do_ccc();
    byte_t code;
    code = byte_t'(rand_bits(8));
    i_chk.note_ccc(code);
    start_cond();
    rx_pulse(`I3C_RSVD_BYTE, REQ_RX_BYTE);
    tx_pulse(REQ_TX_BIT);
    rx_pulse(code, REQ_RX_BYTE);
    wait_req(REQ_CCC);
    bus_delay();
    ccc_done_i <= 1'b1;
    @(posedge clk);
    ccc_done_i <= 1'b0;
    stop_cond();
  endtask

  initial begin
    lfsr_q           = 32'hc17a_0581;
    next_ready       = 1'b1;
    cycles           = 0;
    tx_idx           = 0;
    tx_cnt           = 0;
    target_enable_i  = 1'b1;
    bus_start_det_i  = 1'b0;
    bus_stop_det_i   = 1'b0;
    bus_rx_done_i    = 1'b0;
    bus_rx_data_i    = '0;
    bus_tx_done_i    = 1'b0;
    tx_fifo_rvalid_i = 1'b0;
    tx_fifo_rdata_i  = '0;
    tx_last_byte_i   = 1'b0;
    rx_fifo_wready_i = 1'b1;
    ccc_done_i       = 1'b0;
    {sta_addr, sta_valid, dyn_addr, dyn_valid} = '0;
    @(posedge clk);
    while (!rst_n) @(posedge clk);
    // Dynamic address wins while both are valid
    set_config(7'h2A, 1'b1, 7'h35, 1'b1);
    do_write(7'h35, 4, -1, -1, 1'b0);
    i_chk.end_test("dyn_write", 0, 1, 1, 0);
    start_cond();
    rx_pulse({7'h2A, 1'b0}, REQ_RX_BYTE);
    wait_req(REQ_NACK);
    stop_cond();
    i_chk.end_test("mismatch", 1, 0, 0, 0);
    // The last read byte ends in Wait, which counts as one NACK event
    set_config(7'h2A, 1'b1, 7'h35, 1'b0);
    do_read(7'h2A, 3);
    i_chk.end_test("sta_read", 1, 0, 1, 0);
    set_config(7'h2A, 1'b1, 7'h35, 1'b1);
    do_write(7'h35, 4, 1, -1, 1'b0);
    i_chk.end_test("parity", 0, 1, 1, 0);
    do_ccc();
    i_chk.end_test("ccc", 0, 0, 1, 1);
    do_write(7'h35, 2, -1, -1, 1'b1);
    i_chk.end_test("rep_start", 0, 1, 2, 0);
    do_write(7'h35, 3, -1, 1, 1'b0);
    i_chk.end_test("overflow", 0, 1, 1, 0);
    i_chk.report(i_dut.i_asserts.fail_cnt);
    if (i_chk.err_total == 0 && i_dut.i_asserts.fail_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* tb_i3c_tgt_checker.sv */
// I3C target result checker
// Builds expected FIFO writes, read bytes and counts from the bus rules,
// compares them with the DUT outputs and prints one line per test
`timescale 1ns/10ps
`include "i3c_tgt_macros.svh"

module tb_i3c_tgt_checker (
  input logic               clk_i,
  input logic               rst_ni,
  input logic               wvalid_i,
  input i3c_tgt_pkg::byte_t wdata_i,
  input logic               rx_req_byte_i,
  input logic               rx_req_bit_i,
  input logic               tx_req_byte_i,
  input logic               tx_req_bit_i,
  input logic               tx_done_i,
  input i3c_tgt_pkg::byte_t tx_value_i,
  input logic               pop_i,
  input logic               idle_i,
  input logic               nack_i,
  input logic               perr_i,
  input logic               ovf_i,
  input logic               last_i,
  input i3c_tgt_pkg::byte_t ccc_i,
  input logic               ccc_valid_i
);
  import i3c_tgt_pkg::*;

  byte_t exp_wq[$];
  byte_t exp_rq[$];
  logic  exp_lq[$];
  byte_t exp_ccc;
  logic  sticky, tbit_pending, tbit_exp, req_bit_prev, ccc_prev;
  int    exp_perr, exp_ovf, exp_pop;
  int    nack_cnt, perr_cnt, ovf_cnt, last_cnt, ack_cnt, ccc_cnt, pop_cnt;
  int    test_err, test_total, err_total;

  // Odd parity, the T-bit completes an odd number of ones
  function automatic logic ref_tbit(input byte_t d);
    return ~(^d);
  endfunction

  function automatic void clear_counts();
    {nack_cnt, perr_cnt, ovf_cnt, last_cnt, ack_cnt, ccc_cnt, pop_cnt} = '0;
    {exp_perr, exp_ovf, exp_pop} = '0;
    sticky = 1'b0;
    tbit_pending = 1'b0;
  endfunction

  initial begin
    clear_counts();
    {test_err, test_total, err_total} = '0;
    {req_bit_prev, ccc_prev, tbit_exp} = '0;
    exp_ccc = '0;
  end

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (exp !== got) begin
      $display("ERR %s exp %h got %h", name, exp, got);
      test_err++;
    end
  endtask

  // A byte is written only with a good T-bit, no earlier parity error and room
  task automatic note_write(input byte_t d, input logic tbit, input logic ready);
    if (tbit != ref_tbit(d)) begin
      exp_perr++;
      sticky = 1'b1;
    end else if (!sticky && ready) begin
      exp_wq.push_back(d);
    end
    if (!ready) exp_ovf++;
  endtask

  // One TX FIFO pop per read byte
  task automatic note_read(input byte_t d, input logic last);
    exp_rq.push_back(d);
    exp_lq.push_back(last);
    exp_pop++;
  endtask

  task automatic note_ccc(input byte_t code);
    exp_ccc = code;
  endtask

  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (wvalid_i) begin
        if (exp_wq.size() == 0) begin
          $display("unexpected RX FIFO write of %h", wdata_i);
          test_err++;
        end else begin
          check_val("rx_fifo_wdata_o", exp_wq.pop_front(), wdata_i);
        end
      end
      if (tx_req_byte_i && tx_done_i) begin
        if (exp_rq.size() == 0) begin
          $display("read byte sent with nothing expected");
          test_err++;
        end else begin
          check_val("bus_tx_value_o", exp_rq.pop_front(), tx_value_i);
          tbit_exp = ~exp_lq.pop_front();
          tbit_pending = 1'b1;
        end
      end
      // ACK bits carry 0, read T-bits say whether more data follows
      if (tx_req_bit_i && tx_done_i) begin
        check_val("bus_tx_value_o", tbit_pending ? {7'b0, tbit_exp} : 8'h00, tx_value_i);
        tbit_pending = 1'b0;
      end
      if (tx_req_bit_i && !req_bit_prev && !tbit_pending) ack_cnt++;
      if (ccc_valid_i) check_val("ccc_o", exp_ccc, ccc_i);
      if (ccc_valid_i && !ccc_prev) ccc_cnt++;
      // Idle only between transactions
      if (idle_i && (rx_req_byte_i || rx_req_bit_i || tx_req_byte_i || tx_req_bit_i ||
                     ccc_valid_i)) begin
        check_val("target_idle_o", 1'b0, idle_i);
      end
      nack_cnt += nack_i;
      perr_cnt += perr_i;
      ovf_cnt  += ovf_i;
      last_cnt += last_i;
      pop_cnt  += pop_i;
      req_bit_prev = tx_req_bit_i;
      ccc_prev = ccc_valid_i;
    end
  end

  task automatic end_test(input string name, input int nack, input int last, input int acks,
                          input int cccs);
    @(negedge clk_i);
    // Back in Idle with every receive request low
    check_val("target_idle_o", 1'b1, idle_i);
    check_val("bus_rx_req_byte_o", 1'b0, rx_req_byte_i);
    check_val("bus_rx_req_bit_o", 1'b0, rx_req_bit_i);
    check_val("event_target_nack_o count", nack, nack_cnt);
    check_val("rx_last_byte_o count", last, last_cnt);
    check_val("ACK request count", acks, ack_cnt);
    check_val("ccc_valid_o count", cccs, ccc_cnt);
    check_val("parity_err_o count", exp_perr, perr_cnt);
    check_val("rx_overflow_err_o count", exp_ovf, ovf_cnt);
    check_val("tx_fifo_rready_o count", exp_pop, pop_cnt);
    if (exp_wq.size() != 0) begin
      $display("%0d expected RX FIFO writes never happened", exp_wq.size());
      test_err++;
    end
    if (exp_rq.size() != 0) begin
      $display("%0d expected read bytes were never sent", exp_rq.size());
      test_err++;
    end
    exp_wq.delete();
    exp_rq.delete();
    exp_lq.delete();
    if (test_err == 0) $display("test %-10s ok", name);
    else $display("test %-10s %0d errors", name, test_err);
    test_total++;
    err_total += test_err;
    test_err = 0;
    clear_counts();
  endtask

  task automatic report(input int assert_fails);
    $display("tests run %0d, errors %0d, assertion failures %0d", test_total, err_total,
             assert_fails);
  endtask

endmodule

/* tb_i3c_tgt_clkgen.sv */
// Testbench clock and reset source
// 20 ns clock, active low reset held for the first 10 cycles
`timescale 1ns/10ps

module tb_i3c_tgt_clkgen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (10) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

/* i3c_tgt_asserts.sv */
// I3C target protocol assertions
// Request exclusivity, TX FIFO pops only with data, CCC level held until done
`timescale 1ns/10ps

module i3c_tgt_asserts (
  input logic clk_i,
  input logic rst_ni,
  input logic rx_req_i,
  input logic tx_req_i,
  input logic pop_i,
  input logic rvalid_i,
  input logic ccc_valid_i,
  input logic ccc_done_i
);

  // Assertion failures so far
  int fail_cnt = 0;

  // Receive and transmit requests never overlap
  a_req_excl: assert property (@(posedge clk_i) disable iff (!rst_ni) !(rx_req_i && tx_req_i))
    else begin
      $error("receive and transmit requests are high together");
      fail_cnt++;
    end

  a_pop_valid: assert property (@(posedge clk_i) disable iff (!rst_ni) pop_i |-> rvalid_i)
    else begin
      $error("TX FIFO popped while empty");
      fail_cnt++;
    end

  // CCC handler is released only by its done
  a_ccc_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
                               $fell(ccc_valid_i) |-> $past(ccc_done_i))
    else begin
      $error("ccc_valid_o dropped without ccc_done_i");
      fail_cnt++;
    end

endmodule

bind i3c_tgt_top i3c_tgt_asserts i_asserts (
  .clk_i, .rst_ni,
  .rx_req_i(bus_rx_req_byte_o | bus_rx_req_bit_o),
  .tx_req_i(bus_tx_req_byte_o | bus_tx_req_bit_o),
  .pop_i(tx_fifo_rready_o), .rvalid_i(tx_fifo_rvalid_i),
  .ccc_valid_i(ccc_valid_o), .ccc_done_i
);

/* i3c_tgt_top.sv */
// I3C target control core
// Connects the primary FSM, the address decoder and the RX and TX datapaths
// between the bus monitor and the data FIFOs
`timescale 1ns/10ps
`include "i3c_tgt_macros.svh"

module i3c_tgt_top (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               target_enable_i,
  // Bus monitor
  input  logic               bus_start_det_i,
  input  logic               bus_stop_det_i,
  input  logic               bus_rx_done_i,
  input  i3c_tgt_pkg::byte_t bus_rx_data_i,
  input  logic               bus_tx_done_i,
  output logic               bus_rx_req_byte_o,
  output logic               bus_rx_req_bit_o,
  output logic               bus_tx_req_byte_o,
  output logic               bus_tx_req_bit_o,
  output i3c_tgt_pkg::byte_t bus_tx_value_o,
  // TX FIFO, private read
  input  logic               tx_fifo_rvalid_i,
  input  i3c_tgt_pkg::byte_t tx_fifo_rdata_i,
  input  logic               tx_last_byte_i,
  output logic               tx_fifo_rready_o,
  // RX FIFO, private write
  input  logic               rx_fifo_wready_i,
  output logic               rx_fifo_wvalid_o,
  output i3c_tgt_pkg::byte_t rx_fifo_wdata_o,
  output logic               rx_last_byte_o,
  // Address configuration
  input  i3c_tgt_pkg::addr_t target_sta_addr_i,
  input  logic               target_sta_addr_valid_i,
  input  i3c_tgt_pkg::addr_t target_dyn_addr_i,
  input  logic               target_dyn_addr_valid_i,
  // CCC handler
  output i3c_tgt_pkg::byte_t ccc_o,
  output logic               ccc_valid_o,
  input  logic               ccc_done_i,
  // Status and errors
  output logic               target_idle_o,
  output logic               parity_err_o,
  output logic               rx_overflow_err_o,
  output logic               event_target_nack_o
);

  logic addr_match, rsvd_match, rnw, tx_end;

  i3c_tgt_xfer_if xfer ();

  // Start covers repeated start as well
  assign xfer.start_det = bus_start_det_i;
  assign xfer.stop_det  = bus_stop_det_i;
  assign xfer.rx_done   = bus_rx_done_i;
  assign xfer.rx_data   = bus_rx_data_i;
  assign xfer.tx_done   = bus_tx_done_i;

  i3c_tgt_fsm i_fsm (
    .clk_i, .rst_ni, .xfer(xfer.fsm), .target_enable_i,
    .addr_match_i(addr_match), .rsvd_match_i(rsvd_match), .rnw_i(rnw),
    .tx_end_i(tx_end), .tx_fifo_rvalid_i, .ccc_done_i,
    .bus_rx_req_byte_o, .bus_rx_req_bit_o, .bus_tx_req_byte_o, .bus_tx_req_bit_o,
    .ccc_o, .ccc_valid_o, .target_idle_o, .event_target_nack_o
  );

  i3c_tgt_addr_decode i_addr_decode (
    .clk_i, .rst_ni, .xfer(xfer.path),
    .target_sta_addr_i, .target_sta_addr_valid_i,
    .target_dyn_addr_i, .target_dyn_addr_valid_i,
    .addr_match_o(addr_match), .rsvd_match_o(rsvd_match), .rnw_o(rnw)
  );

  i3c_tgt_rx_path i_rx_path (
    .clk_i, .rst_ni, .xfer(xfer.path), .rx_fifo_wready_i,
    .rx_fifo_wvalid_o, .rx_fifo_wdata_o, .rx_last_byte_o, .parity_err_o,
    .rx_overflow_err_o
  );

  i3c_tgt_tx_path i_tx_path (
    .clk_i, .rst_ni, .xfer(xfer.path), .tx_fifo_rdata_i, .tx_last_byte_i,
    .tx_fifo_rready_o, .bus_tx_value_o, .tx_end_o(tx_end)
  );

endmodule

/* i3c_tgt_tx_path.sv */
// I3C target transmit datapath
// Pops the TX FIFO on entry to a read byte and selects the bus TX value
`timescale 1ns/10ps
`include "i3c_tgt_macros.svh"

module i3c_tgt_tx_path (
  input  logic               clk_i,
  input  logic               rst_ni,
  i3c_tgt_xfer_if.path       xfer,
  input  i3c_tgt_pkg::byte_t tx_fifo_rdata_i,
  input  logic               tx_last_byte_i,
  output logic               tx_fifo_rready_o,
  output i3c_tgt_pkg::byte_t bus_tx_value_o,
  output logic               tx_end_o
);
  import i3c_tgt_pkg::*;

  byte_t data_q;
  logic  end_q;

  // Pop once per read byte
  assign tx_fifo_rready_o = (xfer.state_d == TxPReadData) && (xfer.state_q != TxPReadData);

  always_ff @(posedge clk_i) begin
    if (tx_fifo_rready_o) data_q <= tx_fifo_rdata_i;
  end

  // Last flag sampled together with its byte
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) end_q <= 1'b0;
    else if (tx_fifo_rready_o) end_q <= tx_last_byte_i;
  end

  assign tx_end_o = end_q;

  // ACK states send zero, T-bit says whether more data follows
  always_comb begin
    case (xfer.state_q)
      TxPReadData: bus_tx_value_o = data_q;
      TxPReadTbit: bus_tx_value_o = {{(`I3C_DATA_W-1){1'b0}}, ~end_q};
      default:     bus_tx_value_o = '0;
    endcase
  end

endmodule

/* i3c_tgt_rx_path.sv */
// I3C target receive datapath
// Holds the write data byte, checks the T-bit parity, tracks RX FIFO
// overflow and generates the RX FIFO write strobes
`timescale 1ns/10ps
`include "i3c_tgt_macros.svh"

module i3c_tgt_rx_path (
  input  logic               clk_i,
  input  logic               rst_ni,
  i3c_tgt_xfer_if.path       xfer,
  input  logic               rx_fifo_wready_i,
  output logic               rx_fifo_wvalid_o,
  output i3c_tgt_pkg::byte_t rx_fifo_wdata_o,
  output logic               rx_last_byte_o,
  output logic               parity_err_o,
  output logic               rx_overflow_err_o
);
  import i3c_tgt_pkg::*;

  byte_t data_q;
  logic  tbit_done;
  logic  tbit_fail;
  logic  parity_q;
  logic  wr_enter;
  logic  drop_q;
  logic  ovf_pulse_q;

  // Data byte of a private write
  always_ff @(posedge clk_i) begin
    if (xfer.state_q == RxPWriteData && xfer.rx_done) data_q <= xfer.rx_data;
  end

  // Odd parity, T-bit is the inverted XOR of the data bits
  assign tbit_done = (xfer.state_q == RxPWriteTbit) && xfer.rx_done && !xfer.start_det;
  assign tbit_fail = xfer.rx_data[0] != ~(^data_q);

  assign parity_err_o = tbit_done && tbit_fail;

  // Sticky until idle, blocks the failing byte and the rest
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) parity_q <= 1'b0;
    else if (parity_err_o) parity_q <= 1'b1;
    else if (xfer.state_q == Idle) parity_q <= 1'b0;
  end

  assign wr_enter = (xfer.state_d == RxPWriteData) && (xfer.state_q != RxPWriteData);

  // Per-byte drop flag and overflow pulse
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      drop_q      <= 1'b0;
      ovf_pulse_q <= 1'b0;
    end else begin
      ovf_pulse_q <= wr_enter && !rx_fifo_wready_i;
      if (wr_enter) drop_q <= !rx_fifo_wready_i;
      else if (xfer.state_q == Idle) drop_q <= 1'b0;
    end
  end

  assign rx_overflow_err_o = ovf_pulse_q;

  assign rx_fifo_wvalid_o = tbit_done && !tbit_fail && !parity_q && !drop_q;
  assign rx_fifo_wdata_o  = data_q;

  // Write loop ended by start or stop
  assign rx_last_byte_o = (xfer.state_q == RxPWriteData) &&
                          (xfer.state_d inside {RxFByte, Idle});

endmodule

/* i3c_tgt_fsm.sv */
// I3C target primary FSM
// Walks the address, private transfer and CCC phases, raises the bus
// requests per state, latches the CCC code and flags NACKed transactions
`timescale 1ns/10ps
`include "i3c_tgt_macros.svh"

module i3c_tgt_fsm (
  input  logic               clk_i,
  input  logic               rst_ni,
  i3c_tgt_xfer_if.fsm        xfer,
  input  logic               target_enable_i,
  input  logic               addr_match_i,
  input  logic               rsvd_match_i,
  input  logic               rnw_i,
  input  logic               tx_end_i,
  input  logic               tx_fifo_rvalid_i,
  input  logic               ccc_done_i,
  output logic               bus_rx_req_byte_o,
  output logic               bus_rx_req_bit_o,
  output logic               bus_tx_req_byte_o,
  output logic               bus_tx_req_bit_o,
  output i3c_tgt_pkg::byte_t ccc_o,
  output logic               ccc_valid_o,
  output logic               target_idle_o,
  output logic               event_target_nack_o
);
  import i3c_tgt_pkg::*;

  tgt_state_e state_q, state_d;
  tgt_state_e ack_next;
  byte_t      ccc_q;
  logic       in_wait_q;

  // Shared exit of both ACK states
  // A read with an empty TX FIFO is not started
  always_comb begin
    if (!rnw_i) begin
      ack_next = RxPWriteData;
    end else if (tx_fifo_rvalid_i) begin
      ack_next = TxPReadData;
    end else begin
      ack_next = Wait;
    end
  end

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      Idle: begin
        if (target_enable_i && xfer.start_det) state_d = RxFByte;
      end
      RxFByte: begin
        if (xfer.rx_done) state_d = CheckFByte;
      end
      // One decision cycle on the captured first byte
      CheckFByte: begin
        state_d = (rsvd_match_i || addr_match_i) ? TxAckFByte : Wait;
      end
      TxAckFByte: begin
        if (xfer.tx_done) state_d = rsvd_match_i ? RxSByte : ack_next;
      end
      // After 7E/W either a CCC code or a repeated start
      RxSByte: begin
        if (xfer.start_det) state_d = RxSByteRepeated;
        else if (xfer.rx_done) state_d = DoCCC;
      end
      RxSByteRepeated: begin
        if (xfer.rx_done) state_d = CheckSByte;
      end
      CheckSByte: begin
        state_d = addr_match_i ? TxAckSByte : Wait;
      end
      TxAckSByte: begin
        if (xfer.tx_done) state_d = ack_next;
      end
      RxPWriteData: begin
        if (xfer.start_det) state_d = RxFByte;
        else if (xfer.stop_det) state_d = Idle;
        else if (xfer.rx_done) state_d = RxPWriteTbit;
      end
      RxPWriteTbit: begin
        if (xfer.start_det) state_d = RxFByte;
        else if (xfer.stop_det) state_d = Idle;
        else if (xfer.rx_done) state_d = RxPWriteData;
      end
      TxPReadData: begin
        if (xfer.start_det) state_d = RxFByte;
        else if (xfer.stop_det) state_d = Idle;
        else if (xfer.tx_done) state_d = TxPReadTbit;
      end
      // Stop sending after the last byte or on an empty FIFO
      TxPReadTbit: begin
        if (xfer.start_det) state_d = RxFByte;
        else if (xfer.stop_det) state_d = Idle;
        else if (xfer.tx_done) begin
          state_d = (!tx_end_i && tx_fifo_rvalid_i) ? TxPReadData : Wait;
        end
      end
      // Not addressed, wait for the transaction to end
      Wait: begin
        if (xfer.start_det) state_d = RxFByte;
        else if (xfer.stop_det) state_d = Idle;
      end
      DoCCC: begin
        if (ccc_done_i) state_d = DoneCCC;
      end
      DoneCCC: state_d = Idle;
      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= Idle;
      in_wait_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      in_wait_q <= (state_q == Wait);
    end
  end

  // CCC code is the byte right after the broadcast byte
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ccc_q <= '0;
    end else if (state_q == RxSByte && xfer.rx_done && !xfer.start_det) begin
      ccc_q <= xfer.rx_data;
    end
  end

  // Byte requests drop as soon as a start is seen
  assign bus_rx_req_byte_o = !xfer.start_det &&
                             (state_q inside {RxFByte, RxSByte, RxSByteRepeated, RxPWriteData});
  assign bus_rx_req_bit_o  = !xfer.start_det && (state_q == RxPWriteTbit);
  assign bus_tx_req_byte_o = (state_q == TxPReadData);
  assign bus_tx_req_bit_o  = (state_q inside {TxAckFByte, TxAckSByte, TxPReadTbit});

  assign ccc_o       = ccc_q;
  assign ccc_valid_o = (state_q == DoCCC);

  assign target_idle_o = (state_q == Idle);

  // One pulse in the first Wait cycle
  assign event_target_nack_o = (state_q == Wait) && !in_wait_q;

  assign xfer.state_q = state_q;
  assign xfer.state_d = state_d;

endmodule

/* i3c_tgt_addr_decode.sv */
// I3C target address decoder
// Snapshots the address configuration while idle, captures the address byte
// and matches it against the selected address and the broadcast byte
`timescale 1ns/10ps
`include "i3c_tgt_macros.svh"

module i3c_tgt_addr_decode (
  input  logic               clk_i,
  input  logic               rst_ni,
  i3c_tgt_xfer_if.path       xfer,
  input  i3c_tgt_pkg::addr_t target_sta_addr_i,
  input  logic               target_sta_addr_valid_i,
  input  i3c_tgt_pkg::addr_t target_dyn_addr_i,
  input  logic               target_dyn_addr_valid_i,
  output logic               addr_match_o,
  output logic               rsvd_match_o,
  output logic               rnw_o
);
  import i3c_tgt_pkg::*;

  addr_t sel_addr_q;
  logic  sel_valid_q;
  addr_t addr_q;
  logic  rnw_q;
  logic  addr_capture;

  // Configuration snapshot, dynamic address has precedence over static
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sel_addr_q  <= '0;
      sel_valid_q <= 1'b0;
    end else if (xfer.state_q == Idle) begin
      sel_addr_q  <= target_dyn_addr_valid_i ? target_dyn_addr_i : target_sta_addr_i;
      sel_valid_q <= target_dyn_addr_valid_i | target_sta_addr_valid_i;
    end
  end

  // Bytes that may carry an address
  assign addr_capture = xfer.rx_done &
                        (xfer.state_q inside {RxFByte, RxSByte, RxSByteRepeated});

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q <= '0;
      rnw_q  <= 1'b0;
    end else if (addr_capture) begin
      addr_q <= xfer.rx_data[`I3C_DATA_W-1:1];
      rnw_q  <= xfer.rx_data[0];
    end else if (xfer.state_q == Idle) begin
      addr_q <= '0;
      rnw_q  <= 1'b0;
    end
  end

  // No valid address means no private match at all
  assign addr_match_o = sel_valid_q & (addr_q == sel_addr_q);
  assign rsvd_match_o = ({addr_q, rnw_q} == `I3C_RSVD_BYTE);
  assign rnw_o        = rnw_q;

endmodule

/* i3c_tgt_xfer_if.sv */
// I3C target transfer interface
// Shares the FSM state and the bus monitor events with the datapath blocks
`timescale 1ns/10ps

interface i3c_tgt_xfer_if;
  import i3c_tgt_pkg::*;

  // Current and next primary state
  tgt_state_e state_q;
  tgt_state_e state_d;

  // Bus monitor events, start already merged with repeated start
  logic  start_det;
  logic  stop_det;
  logic  rx_done;
  byte_t rx_data;
  logic  tx_done;

  // State owner
  modport fsm (
    output state_q, state_d,
    input  start_det, stop_det, rx_done, rx_data, tx_done
  );

  // Datapath observers
  modport path (
    input state_q, state_d, start_det, stop_det, rx_done, rx_data, tx_done
  );

endinterface

/* i3c_tgt_pkg.sv */
// I3C target core types
// Byte and address types and the primary FSM state encoding
`include "i3c_tgt_macros.svh"

package i3c_tgt_pkg;

  typedef logic [`I3C_DATA_W-1:0] byte_t;
  typedef logic [`I3C_ADDR_W-1:0] addr_t;

  // Primary transaction states
  typedef enum logic [3:0] {
    Idle,
    RxFByte,
    CheckFByte,
    TxAckFByte,
    RxSByte,
    RxSByteRepeated,
    CheckSByte,
    TxAckSByte,
    RxPWriteData,
    RxPWriteTbit,
    TxPReadData,
    TxPReadTbit,
    Wait,
    DoCCC,
    DoneCCC
  } tgt_state_e;

endpackage

/* i3c_tgt_macros.svh */
// I3C target core constants
// Bus byte and address widths, plus the reserved broadcast byte 7E/W
`ifndef I3C_TGT_MACROS_SVH
`define I3C_TGT_MACROS_SVH

// One SDR byte on the bus
`define I3C_DATA_W 8

// Static and dynamic target addresses
`define I3C_ADDR_W 7

// Broadcast address 7E with the write bit
`define I3C_RSVD_BYTE 8'hFC

`endif
